// File: source/mem_cfg.svh
//****************************************
// cache and main memory sizes and latency
// included by every source that sizes a port
//****************************************
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// byte address and data word
`define MEM_ADDR_W 16
`define MEM_DATA_W 16

// address split: tag 15:11, index 10:3, word offset 2:1
`define MEM_TAG_W 5
`define MEM_INDEX_W 8
`define MEM_WORDS_PER_LINE 4

// cycles the memory stalls per word access
`define MEM_LATENCY 4

`endif

// File: source/mem_pkg.sv
//****************************************
// shared types for controller, ways and memory
//****************************************
`include "mem_cfg.svh"

package mem_pkg;

   // address fields
   typedef logic [`MEM_TAG_W-1:0] tag_t;
   typedef logic [`MEM_INDEX_W-1:0] index_t;
   typedef logic [$clog2(`MEM_WORDS_PER_LINE)-1:0] offset_t;

   // one data word
   typedef logic [`MEM_DATA_W-1:0] word_t;

   // controller states, one access in flight at a time
   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_write_back,
      st_fill,
      st_finish,
      st_fault
   } ctrl_state_t;

endpackage

// File: source/cache_bus_if.sv
//****************************************
// controller-to-way and controller-to-memory buses
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

// one instance per way
interface way_bus_if;
   mem_pkg::index_t  index;
   mem_pkg::offset_t offset;
   mem_pkg::tag_t    tag_in;
   mem_pkg::word_t   data_in;
   logic             comp;
   logic             write;
   logic             valid_in;
   logic             enable;
   // addressed line, combinational
   mem_pkg::tag_t    tag_out;
   mem_pkg::word_t   data_out;
   logic             hit;
   logic             dirty;
   logic             valid;

   modport ctrl (output index, offset, tag_in, data_in, comp, write, valid_in, enable,
                 input tag_out, data_out, hit, dirty, valid);
   modport way (input index, offset, tag_in, data_in, comp, write, valid_in, enable,
                output tag_out, data_out, hit, dirty, valid);
endinterface

interface mem_bus_if;
   logic [`MEM_ADDR_W-1:0] addr;
   mem_pkg::word_t         data_in;
   mem_pkg::word_t         data_out;
   logic                   rd;
   logic                   wr;
   logic                   stall;

   modport ctrl (output addr, data_in, rd, wr, input data_out, stall);
   modport mem (input addr, data_in, rd, wr, output data_out, stall);
endinterface

// File: source/cache_way.sv
//****************************************
// one cache way: tag, valid, dirty and data lines
// reads are combinational, writes land on the clock edge
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_way (
   input  logic   clk,
   input  logic   reset,
   way_bus_if.way bus
);

   localparam int lines = 1 << `MEM_INDEX_W;

   // line storage
   mem_pkg::tag_t  tag_mem [0:lines-1];
   mem_pkg::word_t data_mem [0:lines-1][0:`MEM_WORDS_PER_LINE-1];

   // status bits as flat vectors so reset needs no sweep
   logic [lines-1:0] valid_q;
   logic [lines-1:0] dirty_q;

   logic line_wr;
   logic word_wr;

   // addressed line status
   assign bus.tag_out = tag_mem[bus.index];
   assign bus.valid   = valid_q[bus.index];
   assign bus.dirty   = dirty_q[bus.index];
   assign bus.hit     = valid_q[bus.index] && (tag_mem[bus.index] == bus.tag_in);

   // data only leaves an enabled way
   // lets the top OR both ways together
   assign bus.data_out = bus.enable ? data_mem[bus.index][bus.offset] : '0;

   // fill write: tag, word and valid
   assign line_wr = bus.enable && bus.write && !bus.comp;
   // word lands on a fill or a compare hit
   assign word_wr = line_wr || (bus.enable && bus.write && bus.comp && bus.hit);

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (line_wr) begin
         valid_q[bus.index] <= bus.valid_in;
         // freshly filled line matches memory
         dirty_q[bus.index] <= 1'b0;
      end else if (word_wr) begin
         dirty_q[bus.index] <= 1'b1;
      end
   end

   // payload arrays
   always_ff @(posedge clk) begin
      if (word_wr)
         data_mem[bus.index][bus.offset] <= bus.data_in;
      if (line_wr)
         tag_mem[bus.index] <= bus.tag_in;
   end

   // controller only writes the way it has selected
   a_write_enabled: assert property (
      @(posedge clk) disable iff (reset) bus.write |-> bus.enable
   );

endmodule

// File: source/cache_ctrl.sv
//****************************************
// cache access FSM: hit, write-back, fill, error
// also owns the victim-way bit
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_ctrl (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MEM_ADDR_W-1:0] addr,
   input  mem_pkg::word_t         data_in,
   input  logic                   rd,
   input  logic                   wr,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err,
   way_bus_if.ctrl                way0,
   way_bus_if.ctrl                way1,
   mem_bus_if.ctrl                mem
);

   localparam int off_w  = $clog2(`MEM_WORDS_PER_LINE);
   localparam int cnt_w  = off_w + 1;
   localparam int tag_lo = `MEM_ADDR_W - `MEM_TAG_W;

   mem_pkg::ctrl_state_t state;
   mem_pkg::ctrl_state_t state_nxt;

   // latched request
   mem_pkg::tag_t    tag_q;
   mem_pkg::index_t  index_q;
   mem_pkg::offset_t offset_q;
   mem_pkg::word_t   data_q;
   logic             wr_q;

   logic             hit_q;
   logic             way_sel;
   logic             victim;
   logic             pick;
   logic             pick_dirty;
   // words strobed to memory in this burst
   logic [cnt_w-1:0] sent_cnt;
   logic [cnt_w-1:0] fill_word;
   logic             mem_ready;
   logic             last_sent;
   logic             word_back;
   logic             line_busy;
   logic             way_write;
   mem_pkg::offset_t way_off;

   // memory free: nothing sent yet, or the last word came back
   assign mem_ready = (sent_cnt == '0) || !mem.stall;
   assign last_sent = sent_cnt == cnt_w'(`MEM_WORDS_PER_LINE);
   assign word_back = (sent_cnt != '0) && !mem.stall;
   // word returning now was strobed one count back
   assign fill_word = sent_cnt - 1'b1;

   // hit way first, then invalid way 0, invalid way 1, else victim bit
   always_comb begin
      if (way0.hit)
         pick = 1'b0;
      else if (way1.hit)
         pick = 1'b1;
      else if (!way0.valid)
         pick = 1'b0;
      else if (!way1.valid)
         pick = 1'b1;
      else
         pick = victim;
   end
   assign pick_dirty = pick ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);

   always_comb begin
      state_nxt = state;
      case (state)
         mem_pkg::st_idle:
            if ((rd && wr) || ((rd || wr) && addr[0]))
               state_nxt = mem_pkg::st_fault;
            else if (rd || wr)
               state_nxt = mem_pkg::st_compare;
         mem_pkg::st_compare:
            if (way0.hit || way1.hit)
               state_nxt = mem_pkg::st_finish;
            else if (pick_dirty)
               state_nxt = mem_pkg::st_write_back;
            else
               state_nxt = mem_pkg::st_fill;
         mem_pkg::st_write_back:
            if (last_sent && !mem.stall)
               state_nxt = mem_pkg::st_fill;
         mem_pkg::st_fill:
            if (last_sent && !mem.stall)
               state_nxt = mem_pkg::st_finish;
         default:
            state_nxt = mem_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= mem_pkg::st_idle;
         wr_q     <= 1'b0;
         hit_q    <= 1'b0;
         way_sel  <= 1'b0;
         victim   <= 1'b0;
         sent_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (state == mem_pkg::st_idle)
            wr_q <= wr;
         if (state == mem_pkg::st_compare) begin
            hit_q   <= way0.hit || way1.hit;
            way_sel <= pick;
         end
         // burst counter restarts between write-back and fill
         if (state_nxt != state)
            sent_cnt <= '0;
         else if (mem.rd || mem.wr)
            sent_cnt <= sent_cnt + 1'b1;
         // toggles on every completed access, never on a fault
         if (state == mem_pkg::st_finish)
            victim <= ~victim;
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      if (state == mem_pkg::st_idle) begin
         tag_q    <= addr[`MEM_ADDR_W-1:tag_lo];
         index_q  <= addr[tag_lo-1:off_w+1];
         offset_q <= addr[off_w:1];
         data_q   <= data_in;
      end
   end

   // memory side, strobe as soon as the previous word completes
   assign mem.wr      = (state == mem_pkg::st_write_back) && mem_ready && !last_sent;
   assign mem.rd      = (state == mem_pkg::st_fill) && mem_ready && !last_sent;
   assign mem.addr    = {(state == mem_pkg::st_write_back) ?
                         (way_sel ? way1.tag_out : way0.tag_out) : tag_q,
                         index_q, sent_cnt[off_w-1:0], 1'b0};
   assign mem.data_in = way_sel ? way1.data_out : way0.data_out;

   // way side
   always_comb begin
      case (state)
         mem_pkg::st_write_back:
            way_off = sent_cnt[off_w-1:0];
         mem_pkg::st_fill:
            way_off = fill_word[off_w-1:0];
         default:
            way_off = offset_q;
      endcase
   end
   // fill writes each returning word, finish merges the write data
   assign way_write = ((state == mem_pkg::st_fill) && word_back) ||
                      ((state == mem_pkg::st_finish) && wr_q);
   assign line_busy = (state == mem_pkg::st_write_back) || (state == mem_pkg::st_fill) ||
                      (state == mem_pkg::st_finish);

   assign way0.index    = index_q;
   assign way0.offset   = way_off;
   assign way0.tag_in   = tag_q;
   assign way0.data_in  = (state == mem_pkg::st_fill) ? mem.data_out : data_q;
   assign way0.comp     = state == mem_pkg::st_finish;
   assign way0.valid_in = 1'b1;
   assign way0.enable   = line_busy && !way_sel;
   assign way0.write    = way_write && !way_sel;

   assign way1.index    = index_q;
   assign way1.offset   = way_off;
   assign way1.tag_in   = tag_q;
   assign way1.data_in  = (state == mem_pkg::st_fill) ? mem.data_out : data_q;
   assign way1.comp     = state == mem_pkg::st_finish;
   assign way1.valid_in = 1'b1;
   assign way1.enable   = line_busy && way_sel;
   assign way1.write    = way_write && way_sel;

   // top-level status
   assign stall     = state != mem_pkg::st_idle;
   assign done      = (state == mem_pkg::st_finish) || (state == mem_pkg::st_fault);
   assign err       = state == mem_pkg::st_fault;
   assign cache_hit = (state == mem_pkg::st_finish) && hit_q;

   a_done_pulse: assert property (
      @(posedge clk) disable iff (reset) done |=> !done
   );
   // done or err only after a strobe or while busy
   a_done_cause: assert property (
      @(posedge clk) disable iff (reset) (done || err) |-> $past(stall || rd || wr)
   );

endmodule

// File: source/main_mem.sv
//****************************************
// backing word memory, fixed latency per access
// stall stays high while a word is in flight
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

module main_mem (
   input  logic   clk,
   input  logic   reset,
   mem_bus_if.mem bus
);

   localparam int depth = 1 << (`MEM_ADDR_W - 1);
   localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

   mem_pkg::word_t mem_array [0:depth-1];

   logic [cnt_w-1:0]       busy_cnt;
   logic                   rd_pend;
   logic                   accept;
   logic [`MEM_ADDR_W-2:0] rd_addr;

   // memory starts cleared
   initial begin
      for (int i = 0; i < depth; i++)
         mem_array[i] = '0;
   end

   assign bus.stall = busy_cnt != '0;
   assign accept    = (bus.rd || bus.wr) && !bus.stall;

   // latency counter
   always_ff @(posedge clk) begin
      if (reset) begin
         busy_cnt <= '0;
         rd_pend  <= 1'b0;
      end else if (accept) begin
         busy_cnt <= cnt_w'(`MEM_LATENCY);
         rd_pend  <= bus.rd;
      end else if (busy_cnt != '0) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   // write commits at the strobe
   // read data registered on the last count, valid as stall falls
   always_ff @(posedge clk) begin
      if (accept && bus.wr)
         mem_array[bus.addr[`MEM_ADDR_W-1:1]] <= bus.data_in;
      if (accept && bus.rd)
         rd_addr <= bus.addr[`MEM_ADDR_W-1:1];
      if ((busy_cnt == cnt_w'(1)) && rd_pend)
         bus.data_out <= mem_array[rd_addr];
   end

   // controller waits out the stall before the next word
   a_no_strobe_in_stall: assert property (
      @(posedge clk) disable iff (reset) bus.stall |-> !(bus.rd || bus.wr)
   );

endmodule

// File: source/mem_system.sv
//****************************************
// two-way write-back cache over main memory
// one word access per strobe, done pulses at the end
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_system (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`MEM_ADDR_W-1:0] addr,
   input  logic [`MEM_DATA_W-1:0] data_in,
   input  logic                   rd,
   input  logic                   wr,
   output logic [`MEM_DATA_W-1:0] data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err
);

   way_bus_if way0_bus ();
   way_bus_if way1_bus ();
   mem_bus_if mem_bus ();

   cache_ctrl ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .way0      (way0_bus.ctrl),
      .way1      (way1_bus.ctrl),
      .mem       (mem_bus.ctrl)
   );

   cache_way way0_i (
      .clk   (clk),
      .reset (reset),
      .bus   (way0_bus.way)
   );

   cache_way way1_i (
      .clk   (clk),
      .reset (reset),
      .bus   (way1_bus.way)
   );

   main_mem mem_i (
      .clk   (clk),
      .reset (reset),
      .bus   (mem_bus.mem)
   );

   // at most one way is enabled, the other drives zero
   assign data_out = way0_bus.data_out | way1_bus.data_out;

   // every memory burst ends before the FSM returns to idle
   a_idle_mem_quiet: assert property (
      @(posedge clk) disable iff (reset)
         (ctrl_i.state == mem_pkg::st_idle) |-> !mem_bus.stall
   );

endmodule

// File: bench/mem_system_tb.sv
//****************************************
// random cache traffic against a flat reference model
// run as top module, no plusargs or files
//****************************************
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_system_tb;

   localparam int clk_period   = 8;
   localparam int reset_cycles = 5;
   localparam int n_requests   = 400;
   // one line moved to or from memory
   localparam int line_cycles  = `MEM_WORDS_PER_LINE * (`MEM_LATENCY + 1);
   // strobe, compare, two line phases with a closing cycle each, idle gap
   localparam int worst_cycles = 2 * line_cycles + 5;
   // each request may bring a follow-up read after a fault
   localparam int watchdog_ns  =
      (reset_cycles + 2 * n_requests * (worst_cycles + 1)) * clk_period;

   logic           clk;
   logic           reset;
   logic [15:0]    addr;
   mem_pkg::word_t data_in;
   logic           rd;
   logic           wr;
   mem_pkg::word_t data_out;
   logic           done;
   logic           stall;
   logic           cache_hit;
   logic           err;

   // reference state
   mem_pkg::word_t model_mem [0:32767];
   mem_pkg::tag_t  model_tag [0:1][0:255];
   logic           model_valid [0:1][0:255];
   logic           model_dirty [0:1][0:255];
   logic           model_victim;

   logic [31:0]    lfsr_state;
   int             value_errors;
   int             timing_errors;

   // small pools so lines collide and get evicted
   mem_pkg::tag_t   tag_pool [0:3] = '{5'h00, 5'h07, 5'h13, 5'h1e};
   mem_pkg::index_t index_pool [0:1] = '{8'h05, 8'hc2};

   mem_system mem_system_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(clk_period / 2) clk = ~clk;

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken
   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
   endtask

   // single status output expected low
   task automatic expect_low(input string name, input logic v);
      assert (v === 1'b0) else begin
         value_errors++;
         $display("FAILED at %0t: %s expected 0, got %b", $time, name, v);
      end
   endtask

   // one request: predict, drive, wait for done, check, update model
   task automatic run_access(input logic [15:0] a, input mem_pkg::word_t d,
                             input logic do_rd, input logic do_wr);
      mem_pkg::tag_t   t;
      mem_pkg::index_t idx;
      logic            bad;
      logic            hit;
      logic            w;
      int              exp_cycles;
      int              cycles;
      t   = a[15:11];
      idx = a[10:3];
      bad = a[0] || (do_rd && do_wr);
      hit = 1'b0;
      // hit way, else invalid way 0, invalid way 1, else victim bit
      if (model_valid[0][idx] && model_tag[0][idx] == t) begin
         hit = 1'b1;
         w   = 1'b0;
      end else if (model_valid[1][idx] && model_tag[1][idx] == t) begin
         hit = 1'b1;
         w   = 1'b1;
      end else if (!model_valid[0][idx])
         w = 1'b0;
      else if (!model_valid[1][idx])
         w = 1'b1;
      else
         w = model_victim;
      // strobe and compare, then each line phase ends a cycle after its last word
      if (bad)
         exp_cycles = 1;
      else if (hit)
         exp_cycles = 2;
      else if (model_valid[w][idx] && model_dirty[w][idx])
         exp_cycles = 2 + 2 * (line_cycles + 1);
      else
         exp_cycles = 2 + (line_cycles + 1);

      @(negedge clk);
      addr    = a;
      data_in = d;
      rd      = do_rd;
      wr      = do_wr;
      cycles  = 0;
      do begin
         @(negedge clk);
         // strobes last one cycle
         if (cycles == 0) begin
            rd = 1'b0;
            wr = 1'b0;
         end
         cycles++;
         assert (stall === 1'b1) else begin
            timing_errors++;
            $display("FAILED at %0t: stall expected 1, got %b", $time, stall);
         end
      end while (done !== 1'b1 && cycles < worst_cycles);

      assert (done === 1'b1) else begin
         timing_errors++;
         $display("done never came within %0d cycles of the request to %h, at %0t",
                  worst_cycles, a, $time);
      end

      if (done === 1'b1) begin
         assert (cycles == exp_cycles) else begin
            timing_errors++;
            $display("FAILED at %0t: done cycle expected %0d, got %0d",
                     $time, exp_cycles, cycles);
         end
         assert (err === bad) else begin
            value_errors++;
            $display("FAILED at %0t: err expected %b, got %b", $time, bad, err);
         end
         assert (cache_hit === (hit && !bad)) else begin
            value_errors++;
            $display("FAILED at %0t: cache_hit expected %b, got %b",
                     $time, hit && !bad, cache_hit);
         end
         // never-written words read back as zero
         if (do_rd && !bad) begin
            assert (data_out === model_mem[a[15:1]]) else begin
               value_errors++;
               $display("FAILED at %0t: data_out expected %h, got %h",
                        $time, model_mem[a[15:1]], data_out);
            end
         end
      end

      // refused requests leave model and victim bit alone
      if (!bad) begin
         if (do_wr) begin
            model_mem[a[15:1]]  = d;
            model_dirty[w][idx] = 1'b1;
         end else if (!hit)
            model_dirty[w][idx] = 1'b0;
         model_tag[w][idx]   = t;
         model_valid[w][idx] = 1'b1;
         model_victim        = ~model_victim;
      end
   endtask

   initial begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : stimulus
      logic [15:0] r;
      logic [15:0] a;
      logic [15:0] d;
      logic        odd;
      logic        both;
      logic        is_wr;
      clk           = 1'b0;
      reset         = 1'b1;
      addr          = '0;
      data_in       = '0;
      rd            = 1'b0;
      wr            = 1'b0;
      lfsr_state    = 32'h0b5b427b;
      value_errors  = 0;
      timing_errors = 0;
      model_victim  = 1'b0;
      for (int i = 0; i < 32768; i++)
         model_mem[i] = '0;
      for (int i = 0; i < 256; i++) begin
         model_valid[0][i] = 1'b0;
         model_valid[1][i] = 1'b0;
         model_dirty[0][i] = 1'b0;
         model_dirty[1][i] = 1'b0;
      end

      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      // outputs quiet right after reset
      expect_low("done", done);
      expect_low("stall", stall);
      expect_low("cache_hit", cache_hit);
      expect_low("err", err);

      for (int n = 0; n < n_requests; n++) begin
         draw_bits(2, r);
         a[15:11] = tag_pool[r[1:0]];
         draw_bits(1, r);
         a[10:3] = index_pool[r[0]];
         draw_bits(2, r);
         a[2:1] = r[1:0];
         draw_bits(4, r);
         // about 1 in 16 misaligned
         odd = (r[3:0] == 4'h0);
         a[0] = odd;
         draw_bits(5, r);
         both = (r[4:0] == 5'h00);
         draw_bits(1, r);
         is_wr = r[0];
         draw_bits(16, d);
         if (both)
            run_access(a, d, 1'b1, 1'b1);
         else
            run_access(a, d, !is_wr, is_wr);
         // memory and victim bit must be unchanged by a fault
         if (odd || both)
            run_access({a[15:1], 1'b0}, d, 1'b1, 1'b0);
      end

      $display("errors: %0d value, %0d timing, %0d total",
               value_errors, timing_errors, value_errors + timing_errors);
      if (value_errors + timing_errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+source
source/mem_pkg.sv
source/cache_bus_if.sv
source/cache_way.sv
source/cache_ctrl.sv
source/main_mem.sv
source/mem_system.sv
bench/mem_system_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_system_tb
FILELIST = filelist.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
